// ==== src/soc_pkg.sv ====
package soc_pkg;

  localparam int unsigned IRQ_SOURCES = 3;

  typedef logic [31:0] wb_data_t;
  typedef logic [11:0] wb_addr_t;
  // address bits 11..8
  typedef logic [3:0] region_t;
  // address bits 4..2, word index inside a target
  typedef logic [2:0] reg_idx_t;
  typedef logic [7:0] gpio_t;
  typedef logic [63:0] mtime_t;
  // bit 0 key1, bit 1 SW0, bit 2 SW1
  typedef logic [IRQ_SOURCES-1:0] irq_vec_t;

  // address map
  localparam region_t REGION_GPIO_A = 4'd0;
  localparam region_t REGION_GPIO_B = 4'd1;
  localparam region_t REGION_BOARD = 4'd2;
  localparam region_t REGION_TIMER = 4'd3;
  localparam region_t REGION_IRQ = 4'd4;

  // register indices per target
  localparam reg_idx_t GPIO_DATA = 3'd0;
  localparam reg_idx_t GPIO_DIR = 3'd1;
  localparam reg_idx_t BOARD_SWITCHES = 3'd0;
  localparam reg_idx_t BOARD_LEDS = 3'd1;
  localparam reg_idx_t MTIME_LO = 3'd0;
  localparam reg_idx_t MTIME_HI = 3'd1;
  localparam reg_idx_t MTIMECMP_LO = 3'd2;
  localparam reg_idx_t MTIMECMP_HI = 3'd3;
  localparam reg_idx_t IRQ_PENDING = 3'd0;
  localparam reg_idx_t IRQ_ENABLE = 3'd1;

  // clocks per mtime tick
  localparam logic [31:0] TIMER_DIVIDER = 32'd4;

endpackage

// ==== src/wb_decoder.sv ====
module wb_decoder (
  input  logic              i_clk,
  input  logic              rst_i,
  input  logic              wb_cyc_i,
  input  logic              wb_stb_i,
  input  logic              wb_we_i,
  input  soc_pkg::wb_addr_t wb_adr_i,
  input  soc_pkg::wb_data_t wb_dat_i,
  input  soc_pkg::wb_data_t gpio_a_rd_i,
  input  soc_pkg::wb_data_t gpio_b_rd_i,
  input  soc_pkg::wb_data_t board_rd_i,
  input  soc_pkg::wb_data_t timer_rd_i,
  input  soc_pkg::wb_data_t irq_rd_i,
  output soc_pkg::wb_data_t wb_dat_o,
  output logic              wb_ack_o,
  output logic              wb_err_o,
  output logic              gpio_a_we_o,
  output logic              gpio_b_we_o,
  output logic              board_we_o,
  output logic              timer_we_o,
  output logic              irq_we_o,
  output soc_pkg::reg_idx_t reg_idx_o,
  output soc_pkg::wb_data_t wr_data_o
);

  soc_pkg::region_t  region;
  soc_pkg::wb_data_t rd_sel;
  logic              mapped;
  logic              replied;
  logic              req_new;

  assign region = wb_adr_i[11:8];
  assign reg_idx_o = wb_adr_i[4:2];
  assign wr_data_o = wb_dat_i;

  // first cycle of a request only, one answer per strobe
  assign req_new = wb_cyc_i & wb_stb_i & ~replied;

  always_comb begin
    mapped = 1'b1;
    rd_sel = '0;
    case (region)
      soc_pkg::REGION_GPIO_A: rd_sel = gpio_a_rd_i;
      soc_pkg::REGION_GPIO_B: rd_sel = gpio_b_rd_i;
      soc_pkg::REGION_BOARD:  rd_sel = board_rd_i;
      soc_pkg::REGION_TIMER:  rd_sel = timer_rd_i;
      soc_pkg::REGION_IRQ:    rd_sel = irq_rd_i;
      default:                mapped = 1'b0;
    endcase
  end

  assign gpio_a_we_o = req_new & wb_we_i & (region == soc_pkg::REGION_GPIO_A);
  assign gpio_b_we_o = req_new & wb_we_i & (region == soc_pkg::REGION_GPIO_B);
  assign board_we_o = req_new & wb_we_i & (region == soc_pkg::REGION_BOARD);
  assign timer_we_o = req_new & wb_we_i & (region == soc_pkg::REGION_TIMER);
  assign irq_we_o = req_new & wb_we_i & (region == soc_pkg::REGION_IRQ);

  always_ff @(posedge i_clk) begin
    if (rst_i) begin
      replied <= 1'b0;
      wb_ack_o <= 1'b0;
      wb_err_o <= 1'b0;
    end else begin
      // held until the master drops stb
      if (req_new) begin
        replied <= 1'b1;
      end else if (!(wb_cyc_i && wb_stb_i)) begin
        replied <= 1'b0;
      end
      wb_ack_o <= req_new & mapped;
      wb_err_o <= req_new & ~mapped;
    end
  end

  // unmapped region reads back as zero
  always_ff @(posedge i_clk) begin
    if (req_new) begin
      wb_dat_o <= rd_sel;
    end
  end

endmodule

// ==== src/gpio_port.sv ====
module gpio_port (
  input  logic              i_clk,
  input  logic              rst_i,
  input  logic              we_i,
  input  soc_pkg::reg_idx_t reg_idx_i,
  input  soc_pkg::wb_data_t wr_data_i,
  output soc_pkg::wb_data_t rd_data_o,
  input  soc_pkg::gpio_t    pins_i,
  output soc_pkg::gpio_t    pins_o,
  output soc_pkg::gpio_t    dir_o
);

  soc_pkg::gpio_t out_q;
  // 1 drives the pin
  soc_pkg::gpio_t dir_q;

  always_ff @(posedge i_clk) begin
    if (rst_i) begin
      out_q <= '0;
      dir_q <= '0;
    end else if (we_i) begin
      case (reg_idx_i)
        soc_pkg::GPIO_DATA: out_q <= wr_data_i[7:0];
        soc_pkg::GPIO_DIR:  dir_q <= wr_data_i[7:0];
        default: ;
      endcase
    end
  end

  // data reads the pad levels, not the output register
  always_comb begin
    case (reg_idx_i)
      soc_pkg::GPIO_DATA: rd_data_o = soc_pkg::wb_data_t'(pins_i);
      soc_pkg::GPIO_DIR:  rd_data_o = soc_pkg::wb_data_t'(dir_q);
      default:            rd_data_o = '0;
    endcase
  end

  assign pins_o = out_q;
  assign dir_o = dir_q;

endmodule

// ==== src/board_controls.sv ====
module board_controls (
  input  logic              i_clk,
  input  logic              rst_i,
  input  logic              we_i,
  input  soc_pkg::reg_idx_t reg_idx_i,
  input  soc_pkg::wb_data_t wr_data_i,
  output soc_pkg::wb_data_t rd_data_o,
  input  soc_pkg::irq_vec_t switches_i,
  output soc_pkg::gpio_t    leds_o,
  output soc_pkg::irq_vec_t edge_o
);

  soc_pkg::irq_vec_t sync_meta;
  soc_pkg::irq_vec_t sync_q;
  soc_pkg::irq_vec_t sync_d;
  soc_pkg::gpio_t    leds_q;

  // two-flop synchronizer plus one delayed copy for edges
  always_ff @(posedge i_clk) begin
    if (rst_i) begin
      sync_meta <= '0;
      sync_q <= '0;
      sync_d <= '0;
    end else begin
      sync_meta <= switches_i;
      sync_q <= sync_meta;
      sync_d <= sync_q;
    end
  end

  // one cycle pulse per rising edge
  assign edge_o = sync_q & ~sync_d;

  always_ff @(posedge i_clk) begin
    if (rst_i) begin
      leds_q <= '0;
    end else if (we_i && reg_idx_i == soc_pkg::BOARD_LEDS) begin
      leds_q <= wr_data_i[7:0];
    end
  end

  always_comb begin
    case (reg_idx_i)
      soc_pkg::BOARD_SWITCHES: rd_data_o = soc_pkg::wb_data_t'(sync_q);
      soc_pkg::BOARD_LEDS:     rd_data_o = soc_pkg::wb_data_t'(leds_q);
      default:                 rd_data_o = '0;
    endcase
  end

  assign leds_o = leds_q;

endmodule

// ==== src/machine_timer.sv ====
module machine_timer (
  input  logic              i_clk,
  input  logic              rst_i,
  input  logic              we_i,
  input  soc_pkg::reg_idx_t reg_idx_i,
  input  soc_pkg::wb_data_t wr_data_i,
  output soc_pkg::wb_data_t rd_data_o,
  output logic              irq_o
);

  logic [31:0]      presc;
  logic             tick;
  soc_pkg::mtime_t  mtime;
  soc_pkg::mtime_t  mtimecmp;

  assign tick = (presc == soc_pkg::TIMER_DIVIDER - 32'd1);

  always_ff @(posedge i_clk) begin
    if (rst_i) begin
      presc <= '0;
    end else if (tick) begin
      presc <= '0;
    end else begin
      presc <= presc + 32'd1;
    end
  end

  // software write to a half wins over the tick
  always_ff @(posedge i_clk) begin
    if (rst_i) begin
      mtime <= '0;
    end else if (we_i && reg_idx_i == soc_pkg::MTIME_LO) begin
      mtime[31:0] <= wr_data_i;
    end else if (we_i && reg_idx_i == soc_pkg::MTIME_HI) begin
      mtime[63:32] <= wr_data_i;
    end else if (tick) begin
      mtime <= mtime + 64'd1;
    end
  end

  // all ones keeps the interrupt off until software arms it
  always_ff @(posedge i_clk) begin
    if (rst_i) begin
      mtimecmp <= '1;
    end else if (we_i) begin
      case (reg_idx_i)
        soc_pkg::MTIMECMP_LO: mtimecmp[31:0] <= wr_data_i;
        soc_pkg::MTIMECMP_HI: mtimecmp[63:32] <= wr_data_i;
        default: ;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (rst_i) begin
      irq_o <= 1'b0;
    end else begin
      irq_o <= (mtime >= mtimecmp);
    end
  end

  always_comb begin
    case (reg_idx_i)
      soc_pkg::MTIME_LO:    rd_data_o = mtime[31:0];
      soc_pkg::MTIME_HI:    rd_data_o = mtime[63:32];
      soc_pkg::MTIMECMP_LO: rd_data_o = mtimecmp[31:0];
      soc_pkg::MTIMECMP_HI: rd_data_o = mtimecmp[63:32];
      default:              rd_data_o = '0;
    endcase
  end

endmodule

// ==== src/irq_ctrl.sv ====
module irq_ctrl (
  input  logic              i_clk,
  input  logic              rst_i,
  input  logic              we_i,
  input  soc_pkg::reg_idx_t reg_idx_i,
  input  soc_pkg::wb_data_t wr_data_i,
  output soc_pkg::wb_data_t rd_data_o,
  input  soc_pkg::irq_vec_t sources_i,
  output logic              irq_o
);

  soc_pkg::irq_vec_t pending;
  soc_pkg::irq_vec_t enable;
  soc_pkg::irq_vec_t wr_bits;

  assign wr_bits = wr_data_i[soc_pkg::IRQ_SOURCES-1:0];

  // write one to clear; a pulse in the same cycle sets it again
  always_ff @(posedge i_clk) begin
    if (rst_i) begin
      pending <= '0;
    end else if (we_i && reg_idx_i == soc_pkg::IRQ_PENDING) begin
      pending <= (pending & ~wr_bits) | sources_i;
    end else begin
      pending <= pending | sources_i;
    end
  end

  always_ff @(posedge i_clk) begin
    if (rst_i) begin
      enable <= '0;
    end else if (we_i && reg_idx_i == soc_pkg::IRQ_ENABLE) begin
      enable <= wr_bits;
    end
  end

  always_ff @(posedge i_clk) begin
    if (rst_i) begin
      irq_o <= 1'b0;
    end else begin
      irq_o <= |(pending & enable);
    end
  end

  always_comb begin
    case (reg_idx_i)
      soc_pkg::IRQ_PENDING: rd_data_o = soc_pkg::wb_data_t'(pending);
      soc_pkg::IRQ_ENABLE:  rd_data_o = soc_pkg::wb_data_t'(enable);
      default:              rd_data_o = '0;
    endcase
  end

endmodule

// ==== src/deca_periph_top.sv ====
module deca_periph_top (
  input  logic              i_clk,
  input  logic              rst_i,
  input  logic              wb_cyc_i,
  input  logic              wb_stb_i,
  input  logic              wb_we_i,
  input  soc_pkg::wb_addr_t wb_adr_i,
  input  soc_pkg::wb_data_t wb_dat_i,
  output soc_pkg::wb_data_t wb_dat_o,
  output logic              wb_ack_o,
  output logic              wb_err_o,
  input  soc_pkg::gpio_t    gpio_a_i,
  output soc_pkg::gpio_t    gpio_a_o,
  output soc_pkg::gpio_t    gpio_a_oe_o,
  input  soc_pkg::gpio_t    gpio_b_i,
  output soc_pkg::gpio_t    gpio_b_o,
  output soc_pkg::gpio_t    gpio_b_oe_o,
  input  soc_pkg::irq_vec_t switches_i,
  output soc_pkg::gpio_t    leds_o,
  output logic              timer_irq_o,
  output logic              ext_irq_o
);

  soc_pkg::wb_data_t gpio_a_rd;
  soc_pkg::wb_data_t gpio_b_rd;
  soc_pkg::wb_data_t board_rd;
  soc_pkg::wb_data_t timer_rd;
  soc_pkg::wb_data_t irq_rd;
  soc_pkg::wb_data_t wr_data;
  soc_pkg::reg_idx_t reg_idx;
  soc_pkg::irq_vec_t sw_edge;
  logic              gpio_a_we;
  logic              gpio_b_we;
  logic              board_we;
  logic              timer_we;
  logic              irq_we;

  wb_decoder decoder (
    .i_clk(i_clk), .rst_i(rst_i),
    .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i),
    .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i),
    .gpio_a_rd_i(gpio_a_rd), .gpio_b_rd_i(gpio_b_rd), .board_rd_i(board_rd),
    .timer_rd_i(timer_rd), .irq_rd_i(irq_rd),
    .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o), .wb_err_o(wb_err_o),
    .gpio_a_we_o(gpio_a_we), .gpio_b_we_o(gpio_b_we), .board_we_o(board_we),
    .timer_we_o(timer_we), .irq_we_o(irq_we),
    .reg_idx_o(reg_idx), .wr_data_o(wr_data)
  );

  gpio_port gpio_a (
    .i_clk(i_clk), .rst_i(rst_i), .we_i(gpio_a_we), .reg_idx_i(reg_idx),
    .wr_data_i(wr_data), .rd_data_o(gpio_a_rd),
    .pins_i(gpio_a_i), .pins_o(gpio_a_o), .dir_o(gpio_a_oe_o)
  );

  gpio_port gpio_b (
    .i_clk(i_clk), .rst_i(rst_i), .we_i(gpio_b_we), .reg_idx_i(reg_idx),
    .wr_data_i(wr_data), .rd_data_o(gpio_b_rd),
    .pins_i(gpio_b_i), .pins_o(gpio_b_o), .dir_o(gpio_b_oe_o)
  );

  // key1, SW0, SW1 and the LEDs
  board_controls board (
    .i_clk(i_clk), .rst_i(rst_i), .we_i(board_we), .reg_idx_i(reg_idx),
    .wr_data_i(wr_data), .rd_data_o(board_rd),
    .switches_i(switches_i), .leds_o(leds_o), .edge_o(sw_edge)
  );

  machine_timer timer (
    .i_clk(i_clk), .rst_i(rst_i), .we_i(timer_we), .reg_idx_i(reg_idx),
    .wr_data_i(wr_data), .rd_data_o(timer_rd), .irq_o(timer_irq_o)
  );

  irq_ctrl ictrl (
    .i_clk(i_clk), .rst_i(rst_i), .we_i(irq_we), .reg_idx_i(reg_idx),
    .wr_data_i(wr_data), .rd_data_o(irq_rd),
    .sources_i(sw_edge), .irq_o(ext_irq_o)
  );

endmodule

// ==== dv/periph_asserts.sv ====
module periph_asserts (
  input logic i_clk,
  input logic rst_i,
  input logic cyc_i,
  input logic stb_i,
  input logic ack_i,
  input logic err_i
);

  ack_err_exclusive: assert property (
    @(posedge i_clk) disable iff (rst_i) !(ack_i && err_i)
  ) else $error("wb_decoder drove ack and err in the same cycle");

  // one answer, one cycle long
  reply_single_cycle: assert property (
    @(posedge i_clk) disable iff (rst_i) (ack_i || err_i) |=> !(ack_i || err_i)
  ) else $error("ack or err stayed high for two cycles");

  reply_after_request: assert property (
    @(posedge i_clk) disable iff (rst_i) (ack_i || err_i) |-> $past(cyc_i && stb_i)
  ) else $error("ack or err without a request in the previous cycle");

endmodule

bind wb_decoder periph_asserts bus_checks (
  .i_clk(i_clk),
  .rst_i(rst_i),
  .cyc_i(wb_cyc_i),
  .stb_i(wb_stb_i),
  .ack_i(wb_ack_o),
  .err_i(wb_err_o)
);

// ==== dv/tb_top.sv ====
module tb_top;

  logic              i_clk;
  logic              rst_i;
  logic              wb_cyc;
  logic              wb_stb;
  logic              wb_we;
  soc_pkg::wb_addr_t wb_adr;
  soc_pkg::wb_data_t wb_dat_w;
  soc_pkg::wb_data_t wb_dat_r;
  logic              wb_ack;
  logic              wb_err;
  soc_pkg::gpio_t    gpio_a_in;
  soc_pkg::gpio_t    gpio_a_out;
  soc_pkg::gpio_t    gpio_a_oe;
  soc_pkg::gpio_t    gpio_b_in;
  soc_pkg::gpio_t    gpio_b_out;
  soc_pkg::gpio_t    gpio_b_oe;
  soc_pkg::irq_vec_t switches;
  soc_pkg::gpio_t    leds;
  logic              timer_irq;
  logic              ext_irq;

  integer      seed;
  int          errors;
  int          tests;
  logic [31:0] cycle_count;
  logic [31:0] ack_cycle;

  deca_periph_top UUT (
    .i_clk(i_clk), .rst_i(rst_i),
    .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_we_i(wb_we),
    .wb_adr_i(wb_adr), .wb_dat_i(wb_dat_w), .wb_dat_o(wb_dat_r),
    .wb_ack_o(wb_ack), .wb_err_o(wb_err),
    .gpio_a_i(gpio_a_in), .gpio_a_o(gpio_a_out), .gpio_a_oe_o(gpio_a_oe),
    .gpio_b_i(gpio_b_in), .gpio_b_o(gpio_b_out), .gpio_b_oe_o(gpio_b_oe),
    .switches_i(switches), .leds_o(leds),
    .timer_irq_o(timer_irq), .ext_irq_o(ext_irq)
  );

  initial i_clk = 1'b0;
  always #5 i_clk = ~i_clk;

  always @(posedge i_clk) begin
    cycle_count <= cycle_count + 32'd1;
  end

  // byte address of a register inside a region
  function automatic soc_pkg::wb_addr_t reg_addr(input soc_pkg::region_t region,
                                                 input soc_pkg::reg_idx_t idx);
    return {region, 3'b000, idx, 2'b00};
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("[FAIL] t=%0t %s expected 0x%0h actual 0x%0h", $time, name, expected, actual);
      errors++;
    end
  endtask

  task automatic end_test(input string name, input int errs_start);
    tests++;
    $display("%-16s %s", name, (errors == errs_start) ? "ok" : "mismatches found");
  endtask

  // resp is {err, ack}; zero means no answer
  task automatic bus_access(input logic we, input soc_pkg::wb_addr_t addr,
                            input soc_pkg::wb_data_t wdata,
                            output soc_pkg::wb_data_t rdata, output logic [1:0] resp);
    int waited;
    waited = 0;
    resp = 2'b00;
    rdata = '0;
    @(posedge i_clk);
    wb_cyc <= 1'b1;
    wb_stb <= 1'b1;
    wb_we <= we;
    wb_adr <= addr;
    wb_dat_w <= wdata;
    while (resp == 2'b00 && waited < 20) begin
      @(negedge i_clk);
      waited++;
      if (wb_ack || wb_err) begin
        resp = {wb_err, wb_ack};
        rdata = wb_dat_r;
        ack_cycle = cycle_count;
      end
    end
    @(posedge i_clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we <= 1'b0;
    if (resp == 2'b00) begin
      $display("timeout: no ack or err within 20 cycles at address 0x%03h", addr);
      errors++;
    end
  endtask

  task automatic bus_write(input soc_pkg::wb_addr_t addr, input soc_pkg::wb_data_t data);
    soc_pkg::wb_data_t unused;
    logic [1:0]        resp;
    bus_access(1'b1, addr, data, unused, resp);
    if (resp != 2'b00) begin
      check_value("wb_ack_o", 32'd1, {31'd0, resp == 2'b01});
    end
  endtask

  task automatic bus_read(input soc_pkg::wb_addr_t addr, output soc_pkg::wb_data_t data);
    logic [1:0] resp;
    bus_access(1'b0, addr, '0, data, resp);
    if (resp != 2'b00) begin
      check_value("wb_ack_o", 32'd1, {31'd0, resp == 2'b01});
    end
  endtask

  task automatic wait_irq_high(input logic use_timer, input int limit);
    int   waited;
    logic seen;
    waited = 0;
    seen = 1'b0;
    while (!seen && waited < limit) begin
      @(negedge i_clk);
      waited++;
      seen = use_timer ? timer_irq : ext_irq;
    end
    if (!seen) begin
      $display("timeout: %s did not rise within %0d cycles",
               use_timer ? "timer_irq_o" : "ext_irq_o", limit);
      errors++;
    end
  endtask

  task automatic test_gpio();
    logic [31:0]       rnd;
    soc_pkg::gpio_t    data_b;
    soc_pkg::gpio_t    dir_b;
    soc_pkg::gpio_t    pins_b;
    soc_pkg::wb_data_t rdata;
    soc_pkg::region_t  region;
    int                errs_start;
    errs_start = errors;
    for (int port = 0; port < 2; port++) begin
      region = (port == 0) ? soc_pkg::REGION_GPIO_A : soc_pkg::REGION_GPIO_B;
      rnd = $random(seed);
      data_b = rnd[7:0];
      dir_b = rnd[15:8];
      pins_b = rnd[23:16];
      bus_write(reg_addr(region, soc_pkg::GPIO_DATA), {8'h5a, rnd[31:24], 8'h00, data_b});
      bus_write(reg_addr(region, soc_pkg::GPIO_DIR), 32'(dir_b));
      @(negedge i_clk);
      check_value("gpio_o", 32'(data_b), 32'((port == 0) ? gpio_a_out : gpio_b_out));
      check_value("gpio_oe_o", 32'(dir_b), 32'((port == 0) ? gpio_a_oe : gpio_b_oe));
      bus_read(reg_addr(region, soc_pkg::GPIO_DIR), rdata);
      check_value("GPIO_DIR read", 32'(dir_b), rdata);
      @(posedge i_clk);
      if (port == 0) begin
        gpio_a_in <= pins_b;
      end else begin
        gpio_b_in <= pins_b;
      end
      bus_read(reg_addr(region, soc_pkg::GPIO_DATA), rdata);
      check_value("GPIO_DATA read", 32'(pins_b), rdata);
    end
    end_test("gpio", errs_start);
  endtask

  task automatic test_board();
    logic [31:0]       rnd;
    soc_pkg::wb_data_t rdata;
    int                errs_start;
    errs_start = errors;
    rnd = $random(seed);
    bus_write(reg_addr(soc_pkg::REGION_BOARD, soc_pkg::BOARD_LEDS), 32'(rnd[7:0]));
    @(negedge i_clk);
    check_value("leds_o", 32'(rnd[7:0]), 32'(leds));
    bus_read(reg_addr(soc_pkg::REGION_BOARD, soc_pkg::BOARD_LEDS), rdata);
    check_value("BOARD_LEDS read", 32'(rnd[7:0]), rdata);
    @(posedge i_clk);
    switches <= rnd[10:8];
    repeat (5) @(posedge i_clk);
    bus_read(reg_addr(soc_pkg::REGION_BOARD, soc_pkg::BOARD_SWITCHES), rdata);
    check_value("BOARD_SWITCHES read", 32'(rnd[10:8]), rdata);
    end_test("leds and switches", errs_start);
  endtask

  task automatic test_unmapped();
    soc_pkg::wb_data_t rdata;
    logic [1:0]        resp;
    int                errs_start;
    errs_start = errors;
    bus_access(1'b1, reg_addr(4'd7, 3'd0), $random(seed), rdata, resp);
    check_value("wb_err_o on write", 32'd1, {31'd0, resp[1]});
    check_value("wb_ack_o on write", 32'd0, {31'd0, resp[0]});
    bus_access(1'b0, reg_addr(4'd7, 3'd1), '0, rdata, resp);
    check_value("wb_err_o on read", 32'd1, {31'd0, resp[1]});
    check_value("wb_ack_o on read", 32'd0, {31'd0, resp[0]});
    check_value("wb_dat_o unmapped", 32'd0, rdata);
    end_test("unmapped region", errs_start);
  endtask

  task automatic test_switch_irq();
    soc_pkg::wb_data_t rdata;
    int                errs_start;
    errs_start = errors;
    // settle the switches, then drop whatever earlier edges left pending
    @(posedge i_clk);
    switches <= '0;
    repeat (5) @(posedge i_clk);
    bus_write(reg_addr(soc_pkg::REGION_IRQ, soc_pkg::IRQ_ENABLE), 32'd0);
    bus_write(reg_addr(soc_pkg::REGION_IRQ, soc_pkg::IRQ_PENDING), 32'h7);
    @(posedge i_clk);
    switches <= 3'b010;
    repeat (5) @(posedge i_clk);
    @(negedge i_clk);
    check_value("ext_irq_o while disabled", 32'd0, 32'(ext_irq));
    bus_read(reg_addr(soc_pkg::REGION_IRQ, soc_pkg::IRQ_PENDING), rdata);
    check_value("IRQ_PENDING after SW0 edge", 32'h2, rdata);
    bus_write(reg_addr(soc_pkg::REGION_IRQ, soc_pkg::IRQ_ENABLE), 32'h2);
    wait_irq_high(1'b0, 20);
    bus_write(reg_addr(soc_pkg::REGION_IRQ, soc_pkg::IRQ_PENDING), 32'h2);
    bus_read(reg_addr(soc_pkg::REGION_IRQ, soc_pkg::IRQ_PENDING), rdata);
    check_value("IRQ_PENDING after clear", 32'h0, rdata);
    @(negedge i_clk);
    check_value("ext_irq_o after clear", 32'd0, 32'(ext_irq));
    @(posedge i_clk);
    switches <= '0;
    end_test("switch irq", errs_start);
  endtask

  task automatic test_timer();
    soc_pkg::wb_data_t t0;
    soc_pkg::wb_data_t t1;
    soc_pkg::wb_data_t t_hi;
    logic [31:0]       c0;
    logic [31:0]       gap;
    logic [31:0]       diff;
    logic [31:0]       lo;
    logic [31:0]       hi;
    int                errs_start;
    errs_start = errors;
    bus_read(reg_addr(soc_pkg::REGION_TIMER, soc_pkg::MTIME_LO), t0);
    c0 = ack_cycle;
    repeat (37) @(posedge i_clk);
    bus_read(reg_addr(soc_pkg::REGION_TIMER, soc_pkg::MTIME_LO), t1);
    gap = ack_cycle - c0;
    diff = t1 - t0;
    // one tick per divider period
    lo = gap / soc_pkg::TIMER_DIVIDER;
    hi = (gap + soc_pkg::TIMER_DIVIDER - 32'd1) / soc_pkg::TIMER_DIVIDER;
    check_value("mtime delta ceiling", hi, (diff > hi) ? diff : hi);
    check_value("mtime delta floor", lo, (diff < lo) ? diff : lo);
    // high half first keeps the compare far away until the low half lands
    bus_read(reg_addr(soc_pkg::REGION_TIMER, soc_pkg::MTIME_LO), t0);
    bus_read(reg_addr(soc_pkg::REGION_TIMER, soc_pkg::MTIME_HI), t_hi);
    bus_write(reg_addr(soc_pkg::REGION_TIMER, soc_pkg::MTIMECMP_HI), t_hi);
    bus_write(reg_addr(soc_pkg::REGION_TIMER, soc_pkg::MTIMECMP_LO), t0 + 32'd5);
    @(negedge i_clk);
    check_value("timer_irq_o before match", 32'd0, 32'(timer_irq));
    wait_irq_high(1'b1, 100);
    bus_write(reg_addr(soc_pkg::REGION_TIMER, soc_pkg::MTIMECMP_LO), 32'hffff_ffff);
    bus_write(reg_addr(soc_pkg::REGION_TIMER, soc_pkg::MTIMECMP_HI), 32'hffff_ffff);
    @(negedge i_clk);
    check_value("timer_irq_o after disarm", 32'd0, 32'(timer_irq));
    end_test("machine timer", errs_start);
  endtask

  initial begin
    seed = 32'h7c68bb30;
    errors = 0;
    tests = 0;
    cycle_count = '0;
    ack_cycle = '0;
    rst_i <= 1'b1;
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we <= 1'b0;
    wb_adr <= '0;
    wb_dat_w <= '0;
    gpio_a_in <= '0;
    gpio_b_in <= '0;
    switches <= '0;
    repeat (3) @(posedge i_clk);
    rst_i <= 1'b0;
    test_gpio();
    test_board();
    test_unmapped();
    test_switch_irq();
    test_timer();
    $display("tests run %0d, errors %0d", tests, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// ==== list.f ====
src/soc_pkg.sv
src/wb_decoder.sv
src/gpio_port.sv
src/board_controls.sv
src/machine_timer.sv
src/irq_ctrl.sv
src/deca_periph_top.sv
dv/periph_asserts.sv
dv/tb_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run tb_top with Verilator, then judge the run from sim.log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f list.f --top-module tb_top -o tb_sim \
  > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1 || echo "TEST FAIL" >> sim.log
cat sim.log
grep -q "TEST FAIL" sim.log && exit 1 || exit 0
